/* hw/icache_pkg.sv */
package icache_pkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // address split: tag | set index | byte offset
    localparam int TAG_W = 20;
    localparam int INDEX_W = 7;
    localparam int OFFSET_W = 5;

    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS = 128;

    // bus read type for a whole cache line
    localparam logic [2:0] RD_TYPE_LINE = 3'b100;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [2:0] word_sel_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
    } front_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        logic cache_miss;
        word_t rdata;
    } front_resp_t;

    typedef struct packed {
        logic rd_req;
        logic [2:0] rd_type;
        addr_t rd_addr;
    } mem_req_t;

    typedef struct packed {
        logic rd_rdy;
        logic ret_valid;
        logic ret_last;
        word_t ret_data;
    } mem_resp_t;

    typedef struct packed {
        logic unbusy;
        logic last_hit;
    } cache_status_t;

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_ask_mem,
        s_refill,
        s_write_line
    } ctrl_state_t;

endpackage

/* hw/simple_dual_ram.sv */
`timescale 1ns/10ps

module simple_dual_ram
    import icache_pkg::*;
(
    input logic clk,
    input logic read_en,
    input index_t read_addr,
    output word_t read_data,
    input logic write_en,
    input index_t write_addr,
    input word_t write_data
);

    word_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read, output holds while read_en is low
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* hw/icache_way.sv */
`timescale 1ns/10ps

module icache_way
    import icache_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic read_en,
    input index_t read_index,
    output tag_t tag,
    output logic valid,
    output line_t line,
    input logic write_en,
    input index_t write_index,
    input tag_t write_tag,
    input line_t write_line
);

    logic [NUM_SETS-1:0] valid_bits;
    word_t tag_word;
    word_t tag_wr_word;

    // tag is kept in the low bits of a full-width word
    assign tag_wr_word = {{(WORD_W-TAG_W){1'b0}}, write_tag};
    assign tag = tag_word[TAG_W-1:0];

    simple_dual_ram tag_ram (
        .clk(clk),
        .read_en(read_en),
        .read_addr(read_index),
        .read_data(tag_word),
        .write_en(write_en),
        .write_addr(write_index),
        .write_data(tag_wr_word)
    );

    // one bank per word position of the line
    genvar i;
    generate
        for (i = 0; i < WORDS_PER_LINE; i++) begin : g_bank
            simple_dual_ram bank_ram (
                .clk(clk),
                .read_en(read_en),
                .read_addr(read_index),
                .read_data(line[i*WORD_W +: WORD_W]),
                .write_en(write_en),
                .write_addr(write_index),
                .write_data(write_line[i*WORD_W +: WORD_W])
            );
        end
    endgenerate

    // a set becomes valid once a line has been written into it
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (write_en) begin
            valid_bits[write_index] <= 1'b1;
        end
    end

    // same one-cycle latency as the rams
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (read_en) begin
            valid <= valid_bits[read_index];
        end
    end

endmodule

/* hw/icache_refill.sv */
`timescale 1ns/10ps

module icache_refill
    import icache_pkg::*;
(
    input logic clk,
    input logic reset,
    input mem_resp_t mem_resp,
    output line_t line,
    output logic line_done
);

    word_sel_t word_cnt;
    line_t line_buf;

    // slot of the next returned word
    // holds through gaps in ret_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (mem_resp.ret_valid) begin
            if (mem_resp.ret_last) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_resp.ret_valid) begin
            line_buf[word_cnt*WORD_W +: WORD_W] <= mem_resp.ret_data;
        end
    end

    // one pulse after the last word has landed
    always_ff @(posedge clk) begin
        if (reset) begin
            line_done <= 1'b0;
        end else begin
            line_done <= mem_resp.ret_valid & mem_resp.ret_last;
        end
    end

    assign line = line_buf;

endmodule

/* hw/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl
    import icache_pkg::*;
(
    input logic clk,
    input logic reset,
    input front_req_t front_req,
    output front_resp_t front_resp,
    output mem_req_t mem_req,
    input logic rd_rdy,
    output logic read_en,
    output index_t read_index,
    input tag_t way0_tag,
    input tag_t way1_tag,
    input logic way0_valid,
    input logic way1_valid,
    input line_t way0_line,
    input line_t way1_line,
    input line_t fill_line,
    input logic line_done,
    output logic write_en0,
    output logic write_en1,
    output index_t write_index,
    output tag_t write_tag,
    output cache_status_t status
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    addr_t req_addr;
    tag_t req_tag;
    index_t req_index;
    word_sel_t req_word;

    logic hit0;
    logic hit1;
    logic hit;
    logic accept;
    logic victim;
    logic last_hit;
    logic [NUM_SETS-1:0] lru;

    function automatic word_t pick_word(line_t l, word_sel_t sel);
        return l[sel*WORD_W +: WORD_W];
    endfunction

    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_word = req_addr[OFFSET_W-1 -: 3];

    // tag compare against both ways
    assign hit0 = way0_valid && (way0_tag == req_tag);
    assign hit1 = way1_valid && (way1_tag == req_tag);
    assign hit = hit0 | hit1;

    // new request taken when idle, or right behind a hit
    assign accept = front_req.valid && ((state == s_idle) || (state == s_lookup && hit));

    assign read_en = accept;
    assign read_index = front_req.addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= front_req.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                if (accept) begin
                    next_state = s_lookup;
                end
            end
            s_lookup: begin
                if (!hit) begin
                    next_state = s_ask_mem;
                end else if (!accept) begin
                    next_state = s_idle;
                end
            end
            s_ask_mem: begin
                if (rd_rdy) begin
                    next_state = s_refill;
                end
            end
            s_refill: begin
                if (line_done) begin
                    next_state = s_write_line;
                end
            end
            s_write_line: next_state = s_idle;
            default: next_state = s_idle;
        endcase
    end

    // lru bit points at the way to replace next
    assign victim = lru[req_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (state == s_lookup && hit) begin
            lru[req_index] <= hit0;
        end else if (state == s_write_line) begin
            lru[req_index] <= ~victim;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hit <= 1'b0;
        end else if (state == s_lookup) begin
            last_hit <= hit;
        end
    end

    assign write_en0 = (state == s_write_line) && !victim;
    assign write_en1 = (state == s_write_line) && victim;
    assign write_index = req_index;
    assign write_tag = req_tag;

    // fetch response
    assign front_resp.addr_ok = accept;
    assign front_resp.data_ok = (state == s_lookup && hit) || (state == s_write_line);
    assign front_resp.cache_miss = (state == s_lookup) && !hit;

    always_comb begin
        if (state == s_write_line) begin
            front_resp.rdata = pick_word(fill_line, req_word);
        end else if (hit1) begin
            front_resp.rdata = pick_word(way1_line, req_word);
        end else begin
            front_resp.rdata = pick_word(way0_line, req_word);
        end
    end

    // line-aligned read request, held until rd_rdy
    assign mem_req.rd_req = (state == s_ask_mem);
    assign mem_req.rd_type = RD_TYPE_LINE;
    assign mem_req.rd_addr = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    assign status.unbusy = (state == s_idle);
    assign status.last_hit = last_hit;

endmodule

/* hw/icache.sv */
`timescale 1ns/10ps

module icache
    import icache_pkg::*;
(
    input logic clk,
    input logic reset,
    input front_req_t front_req,
    output front_resp_t front_resp,
    input mem_resp_t mem_resp,
    output mem_req_t mem_req,
    output cache_status_t status
);

    logic read_en;
    index_t read_index;
    tag_t way0_tag;
    tag_t way1_tag;
    logic way0_valid;
    logic way1_valid;
    line_t way0_line;
    line_t way1_line;
    line_t fill_line;
    logic line_done;
    logic write_en0;
    logic write_en1;
    index_t write_index;
    tag_t write_tag;

    icache_way way0 (
        .clk(clk),
        .reset(reset),
        .read_en(read_en),
        .read_index(read_index),
        .tag(way0_tag),
        .valid(way0_valid),
        .line(way0_line),
        .write_en(write_en0),
        .write_index(write_index),
        .write_tag(write_tag),
        .write_line(fill_line)
    );

    icache_way way1 (
        .clk(clk),
        .reset(reset),
        .read_en(read_en),
        .read_index(read_index),
        .tag(way1_tag),
        .valid(way1_valid),
        .line(way1_line),
        .write_en(write_en1),
        .write_index(write_index),
        .write_tag(write_tag),
        .write_line(fill_line)
    );

    // gathers the returned words into one line
    icache_refill refill (
        .clk(clk),
        .reset(reset),
        .mem_resp(mem_resp),
        .line(fill_line),
        .line_done(line_done)
    );

    icache_ctrl ctrl (
        .clk(clk),
        .reset(reset),
        .front_req(front_req),
        .front_resp(front_resp),
        .mem_req(mem_req),
        .rd_rdy(mem_resp.rd_rdy),
        .read_en(read_en),
        .read_index(read_index),
        .way0_tag(way0_tag),
        .way1_tag(way1_tag),
        .way0_valid(way0_valid),
        .way1_valid(way1_valid),
        .way0_line(way0_line),
        .way1_line(way1_line),
        .fill_line(fill_line),
        .line_done(line_done),
        .write_en0(write_en0),
        .write_en1(write_en1),
        .write_index(write_index),
        .write_tag(write_tag),
        .status(status)
    );

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset spans the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/10ps

module mem_model
    import icache_pkg::*;
(
    input logic clk,
    input logic reset,
    input mem_req_t mem_req,
    output mem_resp_t mem_resp
);

    integer seed;

    // one line read: rd_rdy after a random delay, then eight words with gaps
    task automatic serve_line();
        addr_t line_addr;
        int delay;
        int gap;
        int i;
        line_addr = mem_req.rd_addr;
        delay = $unsigned($random(seed)) % 5;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        mem_resp.rd_rdy = 1'b1;
        @(posedge clk);
        #1;
        mem_resp.rd_rdy = 1'b0;
        for (i = 0; i < WORDS_PER_LINE; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            mem_resp.ret_valid = 1'b1;
            mem_resp.ret_last = (i == WORDS_PER_LINE - 1);
            // word at byte address a is a xor 5a5a_0000
            mem_resp.ret_data = (line_addr + 4 * i) ^ 32'h5a5a_0000;
            @(posedge clk);
            #1;
            mem_resp.ret_valid = 1'b0;
            mem_resp.ret_last = 1'b0;
        end
    endtask

    initial begin
        seed = 32'h2a9b_4555;
        mem_resp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && mem_req.rd_req) begin
                serve_line();
            end
        end
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb
    import icache_pkg::*;
();

    localparam int NUM_REQUESTS = 62;
    localparam int MAX_CYCLES = 60 * NUM_REQUESTS + 100;
    localparam word_t DATA_KEY = 32'h5a5a_0000;

    logic clk;
    logic reset;
    front_req_t front_req;
    front_resp_t front_resp;
    mem_req_t mem_req;
    mem_resp_t mem_resp;
    cache_status_t status;

    // reference model: tag and valid per set and way, one lru bit per set
    tag_t model_tag [NUM_SETS][2];
    logic model_valid [NUM_SETS][2];
    logic model_lru [NUM_SETS];

    logic expect_hit;
    addr_t inflight_addr;
    logic miss_pending = 1'b0;
    logic reset_q = 1'b0;
    integer seed;
    int errors = 0;
    int test_start_errors = 0;
    int tests_run = 0;
    int requests = 0;
    int hits = 0;
    int misses = 0;
    int accepted = 0;
    int returned = 0;
    int cycles = 0;

    clock_gen clock_gen_i (.clk(clk), .reset(reset));

    mem_model mem_model_i (.clk(clk), .reset(reset), .mem_req(mem_req), .mem_resp(mem_resp));

    icache icache_i (
        .clk(clk),
        .reset(reset),
        .front_req(front_req),
        .front_resp(front_resp),
        .mem_resp(mem_resp),
        .mem_req(mem_req),
        .status(status)
    );

    // last accepted address and whether a miss is still open
    always @(posedge clk) begin
        reset_q <= reset;
        cycles <= cycles + 1;
        if (reset) begin
            miss_pending <= 1'b0;
        end else begin
            if (front_resp.cache_miss) begin
                miss_pending <= 1'b1;
            end else if (front_resp.data_ok) begin
                miss_pending <= 1'b0;
            end
            if (front_req.valid && front_resp.addr_ok) begin
                inflight_addr <= front_req.addr;
                accepted <= accepted + 1;
            end
            if (front_resp.data_ok) begin
                returned <= returned + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) reset_q |-> (!front_resp.data_ok
        && !front_resp.cache_miss && !mem_req.rd_req && status.unbusy))
    else begin
        errors++;
        $display("outputs active or cache busy around reset at %0t", $time);
    end

    word_check: assert property (@(posedge clk) disable iff (reset)
        front_resp.data_ok |-> front_resp.rdata == (inflight_addr ^ DATA_KEY))
    else begin
        errors++;
        $display("Mismatch rdata: expected %h, got %h",
                 $sampled(inflight_addr) ^ DATA_KEY, $sampled(front_resp.rdata));
    end

    hit_timing: assert property (@(posedge clk) disable iff (reset)
        (front_req.valid && front_resp.addr_ok && expect_hit)
        |=> (front_resp.data_ok && !front_resp.cache_miss))
    else begin
        errors++;
        $display("predicted hit gave no data_ok one cycle after acceptance at %0t", $time);
    end

    miss_flag: assert property (@(posedge clk) disable iff (reset)
        (front_req.valid && front_resp.addr_ok && !expect_hit)
        |=> (front_resp.cache_miss && !front_resp.data_ok))
    else begin
        errors++;
        $display("predicted miss gave no cache_miss in its lookup cycle at %0t", $time);
    end

    // last_hit shows the outcome of the lookup just finished
    last_hit_set: assert property (@(posedge clk) disable iff (reset)
        (front_req.valid && front_resp.addr_ok && expect_hit) |=> ##1 status.last_hit)
    else begin
        errors++;
        $display("Mismatch last_hit: expected %h, got %h", 1'b1, $sampled(status.last_hit));
    end

    last_hit_clear: assert property (@(posedge clk) disable iff (reset)
        (front_req.valid && front_resp.addr_ok && !expect_hit) |=> ##1 !status.last_hit)
    else begin
        errors++;
        $display("Mismatch last_hit: expected %h, got %h", 1'b0, $sampled(status.last_hit));
    end

    read_request: assert property (@(posedge clk) disable iff (reset)
        mem_req.rd_req |-> (miss_pending && mem_req.rd_type == RD_TYPE_LINE
        && mem_req.rd_addr == (inflight_addr & ~32'h1f)))
    else begin
        errors++;
        $display("Mismatch rd_addr/rd_type: expected %h/%h, got %h/%h",
                 $sampled(inflight_addr) & ~32'h1f, RD_TYPE_LINE,
                 $sampled(mem_req.rd_addr), $sampled(mem_req.rd_type));
    end

    // behind a hit a waiting request is taken at once
    back_to_back: assert property (@(posedge clk) disable iff (reset)
        (front_resp.data_ok && !miss_pending && front_req.valid) |-> front_resp.addr_ok)
    else begin
        errors++;
        $display("addr_ok low for a request waiting behind a hit at %0t", $time);
    end

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // the way used becomes the most recent, so the other one is next victim
    task automatic update_model(input addr_t a, output logic hit);
        index_t s;
        tag_t t;
        int way;
        int w;
        s = a[OFFSET_W +: INDEX_W];
        t = a[ADDR_W-1 -: TAG_W];
        hit = 1'b0;
        way = model_lru[s];
        for (w = 0; w < 2; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            model_valid[s][way] = 1'b1;
            model_tag[s][way] = t;
        end
        model_lru[s] = (way == 0);
    endtask

    // entered 1 ns after a rising edge, leaves the same way after acceptance
    task automatic fetch(input addr_t a);
        logic hit;
        update_model(a, hit);
        requests++;
        if (hit) begin
            hits++;
        end else begin
            misses++;
        end
        expect_hit = hit;
        front_req.valid = 1'b1;
        front_req.addr = a;
        @(negedge clk);
        while (!front_resp.addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        front_req.valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!status.unbusy);
        @(posedge clk);
        #1;
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        int i;
        seed = 32'h2a9b_4555;
        front_req = '0;
        expect_hit = 1'b0;
        for (i = 0; i < NUM_SETS; i++) begin
            model_valid[i][0] = 1'b0;
            model_valid[i][1] = 1'b0;
            model_lru[i] = 1'b0;
        end
        do begin
            @(posedge clk);
        end while (reset);
        #1;

        fetch(32'h0000_1040);
        finish_test("reset");

        fetch(32'h0001_2344);
        fetch(32'h0003_4568);
        fetch(32'h0005_6f7c);
        finish_test("cold_miss");

        // every word of the first cold line, back to back
        for (i = 0; i < WORDS_PER_LINE; i++) begin
            fetch(32'h0001_2340 + 4 * i);
        end
        finish_test("hit");

        // two tags in set 9
        fetch(32'h0010_0120);
        fetch(32'h0020_0124);
        fetch(32'h0010_0128);
        fetch(32'h0020_012c);
        fetch(32'h0010_013c);
        fetch(32'h0020_0130);
        finish_test("two_ways");

        // third tag evicts the older one, which then misses
        fetch(32'h0030_0128);
        fetch(32'h0020_0134);
        fetch(32'h0010_0124);
        fetch(32'h0020_0138);
        finish_test("replacement");

        // four tags over four sets
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            fetch({20'h00400 | {18'd0, r[1:0]}, 7'd40 + {5'd0, r[3:2]}, r[6:4], 2'b00});
        end
        finish_test("spread");

        if (accepted != returned) begin
            errors++;
            $display("Mismatch data_ok count: expected %h, got %h", accepted, returned);
        end
        $display("tests %0d, requests %0d, hits %0d, misses %0d, errors %0d",
                 tests_run, requests, hits, misses, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* icache.f */
hw/icache_pkg.sv
hw/simple_dual_ram.sv
hw/icache_way.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/icache_tb.sv
